//--- Makefile
# Verilator build and run of the uart byte analyser testbench
TOP := tb_rx_byte_analyse

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f list.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "^Test completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/rx_byte_analyse.sv
// top of the uart byte analyser
// takes captured characters from the rx shift register, writes good bytes
// to the receive FIFO and keeps per-frame byte counts in a small queue
module rx_byte_analyse (
    input  logic                                    clk,
    input  logic                                    rst,
    // shift register side
    input  logic                                    byte_sync_i,
    input  uart_rx_pkg::char_t                      char_i,
    input  logic                                    baud_tick_i,
    input  uart_rx_pkg::rx_cfg_t                    cfg_i,
    // frame queue read
    input  logic                                    rd_frame_i,
    // receive FIFO write
    output logic [uart_rx_pkg::DATA_W-1:0]          data_o,
    output logic                                    byte_valid_o,
    // status
    output logic                                    parity_err_o,
    output logic                                    frame_err_o,
    output logic [uart_rx_pkg::ERR_CNT_W-1:0]       parity_err_cnt_o,
    output logic [uart_rx_pkg::FRAME_LEN_W-1:0]     frame_info_o,
    output logic [uart_rx_pkg::FRAME_Q_CNT_W-1:0]   frame_cnt_o
);

    uart_rx_pkg::stage_t                  stage;
    logic                                 push;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]  push_len;

    // --------------------------------------------------------------------------
    // character path
    // --------------------------------------------------------------------------
    rx_byte_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .byte_sync_i (byte_sync_i),
        .stage_o     (stage)
    );

    rx_byte_check u_check (
        .clk              (clk),
        .rst              (rst),
        .byte_sync_i      (byte_sync_i),
        .char_i           (char_i),
        .cfg_i            (cfg_i),
        .stage_i          (stage),
        .data_o           (data_o),
        .byte_valid_o     (byte_valid_o),
        .parity_err_o     (parity_err_o),
        .frame_err_o      (frame_err_o),
        .parity_err_cnt_o (parity_err_cnt_o)
    );

    // --------------------------------------------------------------------------
    // frame path
    // --------------------------------------------------------------------------
    // accepted bytes counted from the FIFO write strobe
    rx_frame_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .byte_sync_i  (byte_sync_i),
        .baud_tick_i  (baud_tick_i),
        .byte_valid_i (byte_valid_o),
        .push_o       (push),
        .push_len_o   (push_len)
    );

    rx_frame_queue u_queue (
        .clk          (clk),
        .rst          (rst),
        .push_i       (push),
        .push_len_i   (push_len),
        .rd_i         (rd_frame_i),
        .frame_info_o (frame_info_o),
        .frame_cnt_o  (frame_cnt_o)
    );

endmodule

//--- hw/rx_byte_check.sv
// byte datapath of the uart byte analyser
// buffers the character, restores bit order, checks even parity and stop bit,
// strobes good bytes into the receive FIFO and counts parity errors
module rx_byte_check (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 byte_sync_i,
    input  uart_rx_pkg::char_t                   char_i,
    input  uart_rx_pkg::rx_cfg_t                 cfg_i,
    input  uart_rx_pkg::stage_t                  stage_i,
    output logic [uart_rx_pkg::DATA_W-1:0]       data_o,
    output logic                                 byte_valid_o,
    output logic                                 parity_err_o,
    output logic                                 frame_err_o,
    output logic [uart_rx_pkg::ERR_CNT_W-1:0]    parity_err_cnt_o
);

    uart_rx_pkg::char_t                    char_q;
    uart_rx_pkg::rx_cfg_t                  cfg_q;
    logic [uart_rx_pkg::DATA_W-1:0]        data_rev;
    logic [uart_rx_pkg::DATA_W-1:0]        data_q;
    logic                                  busy;
    logic                                  parity_bad;
    logic                                  parity_err_q;
    logic                                  frame_err_q;
    logic                                  byte_valid_q;
    logic [uart_rx_pkg::ERR_CNT_W-1:0]     err_cnt_q;

    // no stage strobe means the FSM sits in idle
    assign busy = |stage_i;

    // --------------------------------------------------------------------------
    // character and config capture
    // --------------------------------------------------------------------------
    // sync while busy is dropped, the FSM ignores it too
    always_ff @(posedge clk) begin
        if (byte_sync_i && !busy) begin
            char_q <= char_i;
        end
        // config snapshot for this character
        if (stage_i.buff) begin
            cfg_q <= cfg_i;
        end
    end

    // --------------------------------------------------------------------------
    // bit order restore
    // --------------------------------------------------------------------------
    // lsb first: first wire bit becomes bit 0
    always_comb begin
        for (int i = 0; i < uart_rx_pkg::DATA_W; i++) begin
            data_rev[i] = char_q.data[uart_rx_pkg::DATA_W-1-i];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            data_q <= '0;
        end else if (stage_i.order) begin
            // msb first already matches wire order
            data_q <= cfg_q.msb_first ? char_q.data : data_rev;
        end
    end

    // --------------------------------------------------------------------------
    // parity and stop check
    // --------------------------------------------------------------------------
    // even parity, data plus parity bit xor to 0
    assign parity_bad = ^{char_q.data, char_q.parity};

    // flags hold until the next character's check stage
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            parity_err_q <= 1'b0;
            frame_err_q  <= 1'b0;
        end else if (stage_i.check) begin
            parity_err_q <= cfg_q.parity_en & parity_bad;
            frame_err_q  <= ~char_q.stop;
        end
    end

    // --------------------------------------------------------------------------
    // FIFO write and error count
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            byte_valid_q <= 1'b0;
            err_cnt_q    <= '0;
        end else begin
            byte_valid_q <= stage_i.commit & ~parity_err_q & ~frame_err_q;
            // counter wraps
            if (stage_i.commit && parity_err_q) begin
                err_cnt_q <= err_cnt_q + 1'b1;
            end
        end
    end

    assign data_o           = data_q;
    assign byte_valid_o     = byte_valid_q;
    assign parity_err_o     = parity_err_q;
    assign frame_err_o      = frame_err_q;
    assign parity_err_cnt_o = err_cnt_q;

    // flags must stay stable across the commit cycle
    a_no_bad_write: assert property (
        @(posedge clk) disable iff (!rst)
        byte_valid_o |-> !(parity_err_o || frame_err_o)
    );

endmodule

//--- hw/rx_byte_ctrl.sv
// analyse control FSM of the uart byte analyser
// walks BUFF, PARR, CHCK and FIFO once per byte_sync_i and
// raises one stage strobe per state for the datapath
module rx_byte_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                byte_sync_i,
    output uart_rx_pkg::stage_t stage_o
);

    uart_rx_pkg::ana_state_e state_q;
    uart_rx_pkg::ana_state_e state_n;

    // --------------------------------------------------------------------------
    // state sequence
    // --------------------------------------------------------------------------
    // fixed four cycle walk, sync only accepted in idle
    always_comb begin
        case (state_q)
            uart_rx_pkg::IDLE: begin
                if (byte_sync_i) begin
                    state_n = uart_rx_pkg::BUFF;
                end else begin
                    state_n = uart_rx_pkg::IDLE;
                end
            end
            uart_rx_pkg::BUFF: state_n = uart_rx_pkg::PARR;
            uart_rx_pkg::PARR: state_n = uart_rx_pkg::CHCK;
            uart_rx_pkg::CHCK: state_n = uart_rx_pkg::FIFO;
            uart_rx_pkg::FIFO: state_n = uart_rx_pkg::IDLE;
            // illegal code, back to idle
            default:           state_n = uart_rx_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= uart_rx_pkg::IDLE;
        end else begin
            state_q <= state_n;
        end
    end

    // --------------------------------------------------------------------------
    // stage strobes
    // --------------------------------------------------------------------------
    // each strobe marks the cycle that ends with the state's exit
    assign stage_o.buff   = (state_q == uart_rx_pkg::BUFF);
    assign stage_o.order  = (state_q == uart_rx_pkg::PARR);
    assign stage_o.check  = (state_q == uart_rx_pkg::CHCK);
    assign stage_o.commit = (state_q == uart_rx_pkg::FIFO);

    // state register stays one-hot
    a_state_onehot: assert property (
        @(posedge clk) disable iff (!rst) $onehot(state_q)
    );

    // shift register must hold the next character until the FSM is back in idle
    a_sync_in_idle: assert property (
        @(posedge clk) disable iff (!rst) byte_sync_i |-> (state_q == uart_rx_pkg::IDLE)
    );

endmodule

//--- hw/rx_frame_queue.sv
// frame record queue of the uart byte analyser
// four entry shift queue, oldest at entry 0, overwrite-oldest when full;
// a read strobe moves the oldest record to frame_info_o
module rx_frame_queue (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    push_i,
    input  logic [uart_rx_pkg::FRAME_LEN_W-1:0]     push_len_i,
    input  logic                                    rd_i,
    output logic [uart_rx_pkg::FRAME_LEN_W-1:0]     frame_info_o,
    output logic [uart_rx_pkg::FRAME_Q_CNT_W-1:0]   frame_cnt_o
);

    logic [uart_rx_pkg::FRAME_LEN_W-1:0]    mem_q [uart_rx_pkg::FRAME_Q_DEPTH];
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]    mem_n [uart_rx_pkg::FRAME_Q_DEPTH];
    logic [uart_rx_pkg::FRAME_Q_CNT_W-1:0]  cnt_q;
    logic [uart_rx_pkg::FRAME_Q_CNT_W-1:0]  cnt_n;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]    info_q;
    logic                                   rd_ok;
    logic                                   full;
    logic                                   shift;

    assign full  = (cnt_q == uart_rx_pkg::FRAME_Q_CNT_W'(uart_rx_pkg::FRAME_Q_DEPTH));
    // empty read is a no-op
    assign rd_ok = rd_i && (cnt_q != '0);
    // read or overflow both drop entry 0
    assign shift = rd_ok || (push_i && full);

    // --------------------------------------------------------------------------
    // next queue contents
    // --------------------------------------------------------------------------
    // read served first, push appends behind the remaining entries
    always_comb begin
        mem_n = mem_q;
        cnt_n = cnt_q;
        if (shift) begin
            for (int i = 0; i < uart_rx_pkg::FRAME_Q_DEPTH - 1; i++) begin
                mem_n[i] = mem_q[i+1];
            end
            cnt_n = cnt_q - 1'b1;
        end
        if (push_i) begin
            for (int i = 0; i < uart_rx_pkg::FRAME_Q_DEPTH; i++) begin
                if (cnt_n == uart_rx_pkg::FRAME_Q_CNT_W'(i)) begin
                    mem_n[i] = push_len_i;
                end
            end
            cnt_n = cnt_n + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        mem_q <= mem_n;
    end

    // occupancy and registered read port
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt_q  <= '0;
            info_q <= '0;
        end else begin
            cnt_q <= cnt_n;
            if (rd_ok) begin
                info_q <= mem_q[0];
            end
        end
    end

    assign frame_info_o = info_q;
    assign frame_cnt_o  = cnt_q;

    // overwrite-oldest keeps occupancy bounded
    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!rst)
        cnt_q <= uart_rx_pkg::FRAME_Q_CNT_W'(uart_rx_pkg::FRAME_Q_DEPTH)
    );

endmodule

//--- hw/rx_frame_tracker.sv
// frame recognition of the uart byte analyser
// counts baud ticks since the last character and accepted bytes per frame,
// pushes the byte count once the idle gap reaches FRAME_GAP_TICKS
module rx_frame_tracker (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  byte_sync_i,
    input  logic                                  baud_tick_i,
    input  logic                                  byte_valid_i,
    output logic                                  push_o,
    output logic [uart_rx_pkg::FRAME_LEN_W-1:0]   push_len_o
);

    logic [uart_rx_pkg::GAP_CNT_W-1:0]    gap_q;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]  len_q;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]  len_n;
    logic                                 gap_hit;
    logic                                 close;
    logic                                 push_q;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]  push_len_q;

    // --------------------------------------------------------------------------
    // gap counter
    // --------------------------------------------------------------------------
    // starts saturated so nothing closes before the first character
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            gap_q <= '1;
        end else if (byte_sync_i) begin
            gap_q <= '0;
        end else if (baud_tick_i && (gap_q != '1)) begin
            gap_q <= gap_q + 1'b1;
        end
    end

    // this tick brings the gap to exactly the threshold
    assign gap_hit = baud_tick_i && !byte_sync_i &&
        (gap_q == uart_rx_pkg::GAP_CNT_W'(uart_rx_pkg::FRAME_GAP_TICKS - 1));

    // --------------------------------------------------------------------------
    // byte counter and frame close
    // --------------------------------------------------------------------------
    // count includes a byte accepted in the closing cycle
    assign len_n = len_q + uart_rx_pkg::FRAME_LEN_W'(byte_valid_i);
    // empty frames push nothing
    assign close = gap_hit && (len_n != '0);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            len_q  <= '0;
            push_q <= 1'b0;
        end else begin
            push_q <= close;
            len_q  <= close ? '0 : len_n;
        end
    end

    always_ff @(posedge clk) begin
        if (close) begin
            push_len_q <= len_n;
        end
    end

    assign push_o     = push_q;
    assign push_len_o = push_len_q;

endmodule

//--- hw/uart_rx_pkg.sv
// shared widths, bit positions, thresholds and types of the uart byte analyser
// referenced by scoped names from the rtl and the testbench
package uart_rx_pkg;

    // --------------------------------------------------------------------------
    // character layout, start bit first on the wire
    // --------------------------------------------------------------------------
    localparam int CHAR_W = 12;
    localparam int DATA_W = 8;
    // first received data bit sits just below the start bit
    localparam int CHAR_START_BIT  = CHAR_W - 1;
    localparam int CHAR_DATA_HI    = CHAR_START_BIT - 1;
    localparam int CHAR_DATA_LO    = CHAR_DATA_HI - DATA_W + 1;
    localparam int CHAR_PARITY_BIT = CHAR_DATA_LO - 1;
    localparam int CHAR_STOP_BIT   = CHAR_PARITY_BIT - 1;

    // --------------------------------------------------------------------------
    // frame recognition
    // --------------------------------------------------------------------------
    // baud ticks in one character incl. start, parity and stop
    localparam int CHAR_TICKS      = 11;
    // idle gap that closes a frame
    localparam int FRAME_GAP_TICKS = CHAR_TICKS + 17;
    localparam int GAP_CNT_W       = 8;

    // frame queue and error counter
    localparam int FRAME_LEN_W   = 8;
    localparam int FRAME_Q_DEPTH = 4;
    localparam int FRAME_Q_CNT_W = 3;
    localparam int ERR_CNT_W     = 8;

    // --------------------------------------------------------------------------
    // types
    // --------------------------------------------------------------------------
    // captured character, data kept in wire order
    typedef struct packed {
        logic                                 start;
        logic [CHAR_DATA_HI-CHAR_DATA_LO:0]   data;
        logic                                 parity;
        logic                                 stop;
        logic [CHAR_STOP_BIT-1:0]             spare;
    } char_t;

    typedef struct packed {
        logic parity_en;
        logic msb_first;
    } rx_cfg_t;

    // one strobe per analyse stage
    typedef struct packed {
        logic buff;
        logic order;
        logic check;
        logic commit;
    } stage_t;

    // one-hot analyse states
    typedef enum logic [4:0] {
        IDLE = 5'b00001,
        BUFF = 5'b00010,
        PARR = 5'b00100,
        CHCK = 5'b01000,
        FIFO = 5'b10000
    } ana_state_e;

endpackage

//--- list.f
+incdir+test
hw/uart_rx_pkg.sv
hw/rx_byte_ctrl.sv
hw/rx_byte_check.sv
hw/rx_frame_tracker.sv
hw/rx_frame_queue.sv
hw/rx_byte_analyse.sv
test/tb_rx_byte_analyse.sv

//--- test/tb_rx_vectors.svh
// stimulus rows for the uart byte analyser testbench
// included inside the testbench module after the vec_t typedef
`ifndef TB_RX_VECTORS_SVH
`define TB_RX_VECTORS_SVH

localparam int NUM_VECTORS = 16;

// columns: data, rnd_data, parity_en, msb_first, bad_parity, stop, gap_ticks, reads
// gaps stay well clear of the 28 tick frame threshold, 2 keeps a frame open, 34 closes it
localparam vec_t VECTORS [NUM_VECTORS] = '{
    // frame of four accepted bytes plus two rejects
    '{8'hA5, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 8'd2,  3'd0},
    '{8'h3C, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'd2,  3'd0},
    '{8'h00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 8'd2,  3'd0},
    '{8'h5A, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 8'd2,  3'd0},
    // same wrong parity, checking off
    '{8'h5A, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 8'd2,  3'd0},
    '{8'hC3, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 8'd34, 3'd1},
    // rejected only, then a read of the empty queue
    '{8'h81, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 8'd34, 3'd1},
    // five frames of 1, 2, 3, 1 and 2 bytes without a read
    '{8'h00, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 8'd34, 3'd0},
    '{8'h12, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 8'd2,  3'd0},
    '{8'h00, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 8'd34, 3'd0},
    '{8'h00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 8'd2,  3'd0},
    '{8'h7E, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 8'd2,  3'd0},
    '{8'h00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 8'd34, 3'd0},
    '{8'hE7, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 8'd34, 3'd0},
    '{8'h00, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 8'd2,  3'd0},
    // overflow, drain all four and one empty read
    '{8'h0F, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 8'd34, 3'd5}
};

`endif

//--- test/tb_rx_byte_analyse.sv
// testbench of the uart byte analyser
// applies the stimulus table, models bytes, flags, error count and frame queue
// from the timing rules and compares every output cycle by cycle
module tb_rx_byte_analyse;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    // sync edge up to one cycle past the write strobe
    localparam int CHAR_CYCLES  = 6;
    localparam int TICK_CYCLES  = 4;

    typedef struct packed {
        logic [7:0] data;
        logic       rnd_data;
        logic       parity_en;
        logic       msb_first;
        logic       bad_parity;
        logic       stop;
        logic [7:0] gap_ticks;
        logic [2:0] reads;
    } vec_t;

    `include "tb_rx_vectors.svh"

    logic                                   clk;
    logic                                   rst;
    logic                                   byte_sync_i;
    uart_rx_pkg::char_t                     char_i;
    logic                                   baud_tick_i;
    uart_rx_pkg::rx_cfg_t                   cfg_i;
    logic                                   rd_frame_i;
    logic [uart_rx_pkg::DATA_W-1:0]         data_o;
    logic                                   byte_valid_o;
    logic                                   parity_err_o;
    logic                                   frame_err_o;
    logic [uart_rx_pkg::ERR_CNT_W-1:0]      parity_err_cnt_o;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]    frame_info_o;
    logic [uart_rx_pkg::FRAME_Q_CNT_W-1:0]  frame_cnt_o;

    int                                     errors = 0;
    int                                     tick_count = 0;
    // reference model state
    logic [uart_rx_pkg::ERR_CNT_W-1:0]      model_err_cnt;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]    model_len;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]    model_info;
    logic [uart_rx_pkg::FRAME_LEN_W-1:0]    model_q [$];

    rx_byte_analyse dut (
        .clk              (clk),
        .rst              (rst),
        .byte_sync_i      (byte_sync_i),
        .char_i           (char_i),
        .baud_tick_i      (baud_tick_i),
        .cfg_i            (cfg_i),
        .rd_frame_i       (rd_frame_i),
        .data_o           (data_o),
        .byte_valid_o     (byte_valid_o),
        .parity_err_o     (parity_err_o),
        .frame_err_o      (frame_err_o),
        .parity_err_cnt_o (parity_err_cnt_o),
        .frame_info_o     (frame_info_o),
        .frame_cnt_o      (frame_cnt_o)
    );

    // ------------------------------------------------------------------------
    // clock, baud ticks and tick count
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one tick every four cycles once out of reset
    initial begin
        baud_tick_i = 1'b0;
        wait (rst === 1'b1);
        forever begin
            repeat (TICK_CYCLES - 1) @(negedge clk);
            baud_tick_i = 1'b1;
            @(negedge clk);
            baud_tick_i = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (baud_tick_i) begin
            tick_count <= tick_count + 1;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_frame_outputs();
        check_value("frame_cnt_o", 32'(frame_cnt_o), 32'(model_q.size()));
        check_value("frame_info_o", 32'(frame_info_o), 32'(model_info));
    endtask

    task automatic check_reset_values();
        check_value("byte_valid_o", 32'(byte_valid_o), 32'd0);
        check_value("parity_err_o", 32'(parity_err_o), 32'd0);
        check_value("frame_err_o", 32'(frame_err_o), 32'd0);
        check_value("parity_err_cnt_o", 32'(parity_err_cnt_o), 32'd0);
        check_frame_outputs();
    endtask

    // first wire bit ends up in bit 7 of the char data field
    function automatic logic [7:0] reverse_bits(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < uart_rx_pkg::DATA_W; i++) begin
            r[i] = b[uart_rx_pkg::DATA_W-1-i];
        end
        return r;
    endfunction

    task automatic wait_ticks(input int n);
        int start;
        start = tick_count;
        while (tick_count - start < n) @(negedge clk);
    endtask

    // drives one character and follows it through the four busy cycles
    task automatic send_char(input vec_t row);
        logic [7:0]                         byte_val;
        logic                               exp_perr;
        logic                               exp_ferr;
        logic                               exp_valid;
        logic [uart_rx_pkg::ERR_CNT_W-1:0]  cnt_before;
        byte_val   = row.rnd_data ? 8'($urandom()) : row.data;
        exp_perr   = row.parity_en & row.bad_parity;
        exp_ferr   = ~row.stop;
        exp_valid  = !exp_perr && !exp_ferr;
        cnt_before = model_err_cnt;
        if (exp_perr) begin
            model_err_cnt = model_err_cnt + uart_rx_pkg::ERR_CNT_W'(1);
        end
        if (exp_valid) begin
            model_len = model_len + uart_rx_pkg::FRAME_LEN_W'(1);
        end
        cfg_i.parity_en = row.parity_en;
        cfg_i.msb_first = row.msb_first;
        char_i.start    = 1'b0;
        char_i.data     = row.msb_first ? byte_val : reverse_bits(byte_val);
        // even parity over the data, flipped on request
        char_i.parity   = (^byte_val) ^ row.bad_parity;
        char_i.stop     = row.stop;
        char_i.spare    = '0;
        byte_sync_i     = 1'b1;
        for (int k = 1; k <= CHAR_CYCLES; k++) begin
            @(negedge clk);
            byte_sync_i = 1'b0;
            // strobe only in the fifth cycle after the sync edge
            check_value("byte_valid_o", 32'(byte_valid_o), 32'(k == 5 && exp_valid));
            if (k >= 3) begin
                check_value("data_o", 32'(data_o), 32'(byte_val));
            end
            if (k >= 4) begin
                check_value("parity_err_o", 32'(parity_err_o), 32'(exp_perr));
                check_value("frame_err_o", 32'(frame_err_o), 32'(exp_ferr));
            end
            check_value("parity_err_cnt_o", 32'(parity_err_cnt_o),
                        32'((k >= 5) ? model_err_cnt : cnt_before));
            check_frame_outputs();
        end
    endtask

    // idle gap after a row, a long one closes a frame with accepted bytes
    task automatic close_gap(input vec_t row);
        wait_ticks(int'(row.gap_ticks));
        if (int'(row.gap_ticks) >= uart_rx_pkg::FRAME_GAP_TICKS) begin
            if (model_len != '0) begin
                if (model_q.size() == uart_rx_pkg::FRAME_Q_DEPTH) begin
                    void'(model_q.pop_front());
                end
                model_q.push_back(model_len);
            end
            model_len = '0;
        end
        check_frame_outputs();
    endtask

    task automatic read_frame();
        // empty queue keeps the last record
        if (model_q.size() != 0) begin
            model_info = model_q.pop_front();
        end
        rd_frame_i = 1'b1;
        @(negedge clk);
        rd_frame_i = 1'b0;
        check_frame_outputs();
    endtask

    function automatic int watchdog_cycles();
        int total;
        total = RESET_CYCLES + 2;
        for (int r = 0; r < NUM_VECTORS; r++) begin
            total += CHAR_CYCLES + TICK_CYCLES * (int'(VECTORS[r].gap_ticks) + 1);
            total += int'(VECTORS[r].reads);
        end
        return 2 * total;
    endfunction

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        rst           = 1'b0;
        byte_sync_i   = 1'b0;
        char_i        = '0;
        cfg_i         = '0;
        rd_frame_i    = 1'b0;
        model_err_cnt = '0;
        model_len     = '0;
        model_info    = '0;
        void'($urandom(33));
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_reset_values();
        for (int r = 0; r < NUM_VECTORS; r++) begin
            send_char(VECTORS[r]);
            close_gap(VECTORS[r]);
            repeat (VECTORS[r].reads) read_frame();
        end
        @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run limit from the table length
    initial begin
        #(watchdog_cycles() * CLK_PERIOD);
        $display("watchdog expired, the stimulus table did not finish in time");
        $display("errors: %0d", errors);
        $display("Test failed");
        $finish;
    end

endmodule
